/* Bender.yml */
package:
  name: lenet_conv

export_include_dirs:
  - common

sources:
  - files:
      - common/lenet_pkg.sv
      - hw/lenet_xwyf_16.sv
      - conv/conv_weight_mem.sv
      - conv/conv_ctrl.sv
      - conv/conv_mac.sv
      - hw/out_quant.sv
      - hw/lenet_conv_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/lenet_conv_sva.sv
      - bench/lenet_conv_tb.sv

/* bench/lenet_conv_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_conv_sva import lenet_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       out_valid,
    input conv_beat_t beat
);

    // Every window yields a single result strobe.
    out_valid_single: assert property (
        @(posedge clk) disable iff (rst) out_valid |=> !out_valid
    ) else $error("out_valid stayed high for more than one cycle");

    // Synchronous reset leaves the engine idle with no result pending.
    idle_after_reset: assert property (
        @(posedge clk) rst |=> (!busy && !out_valid)
    ) else $error("busy or out_valid high after reset");

    // Product register, accumulator, then the output register.
    last_to_out: assert property (
        @(posedge clk) disable iff (rst) beat.last |-> ##3 out_valid
    ) else $error("no out_valid three cycles after the last beat");

    out_from_last: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> $past(beat.last, 3)
    ) else $error("out_valid without a last beat three cycles before");

endmodule

bind lenet_conv_top lenet_conv_sva sva0 (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .out_valid (out_valid),
    .beat      (beat)
);

`default_nettype wire

/* bench/lenet_conv_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lenet_config.svh"

module lenet_conv_tb import lenet_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_GAP      = 3;
    localparam int N_WINDOWS    = 28;
    // Start, beats with their worst gaps, a full weight load and the pipeline.
    localparam int WIN_CYCLES   = 1 + `LENET_TAPS * (1 + MAX_GAP) + `LENET_TAPS + 8;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + N_WINDOWS * WIN_CYCLES + 50) * CLK_PERIOD;

    typedef struct packed {
        pixel_t      pix;
        acc_t        sum;
        logic [31:0] due;  // Cycle count at which out_valid is seen.
    } result_t;

    logic    clk;
    logic    rst;
    logic    w_we;
    tap_t    w_addr;
    weight_t w_data;
    logic    start;
    logic    pix_valid;
    pixel_t  pix;
    bias_t   bias;
    logic    busy;
    logic    out_valid;
    pixel_t  out_pix;
    acc_t    out_sum;

    logic [15:0] lfsr_state;
    logic [31:0] cyc;
    weight_t     w_model [`LENET_TAPS];
    pixel_t      px_buf [`LENET_TAPS];
    result_t     exp_q [$];

    lenet_conv_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .w_we      (w_we),
        .w_addr    (w_addr),
        .w_data    (w_data),
        .start     (start),
        .pix_valid (pix_valid),
        .pix       (pix),
        .bias      (bias),
        .busy      (busy),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_sum   (out_sum)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int unsigned random_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic int unsigned gated_bit(pixel_t x, weight_t y, int i, int j);
        return int'(x[i] & y[j]);
    endfunction

    function automatic int unsigned xor_bits(pixel_t x, weight_t y, int a, int b, int c, int d);
        return gated_bit(x, y, a, b) ^ gated_bit(x, y, c, d);
    endfunction

    function automatic int unsigned or_bits(pixel_t x, weight_t y, int a, int b, int c, int d);
        return gated_bit(x, y, a, b) | gated_bit(x, y, c, d);
    endfunction

    function automatic int unsigned and_bits(pixel_t x, weight_t y, int a, int b, int c, int d);
        return gated_bit(x, y, a, b) & gated_bit(x, y, c, d);
    endfunction

    // Each approximate term sits at the bit position the reference multiplier gives it.
    function automatic product_t approx_mul(pixel_t x, weight_t y);
        int unsigned p;
        p = 0;
        for (int j = 0; j < 8; j++) begin
            p += gated_bit(x, y, 6, j) << (6 + j);  // Rows 6 and 7 are exact.
            p += gated_bit(x, y, 7, j) << (7 + j);
        end
        p += gated_bit(x, y, 5, 7) << 12;
        p += gated_bit(x, y, 3, 7) << 10;
        p += gated_bit(x, y, 1, 7) << 8;
        p += (and_bits(x, y, 4, 6, 5, 5) + and_bits(x, y, 4, 7, 5, 6)) << 11;
        p += and_bits(x, y, 4, 5, 5, 4) << 10;
        p += (and_bits(x, y, 2, 6, 3, 5) + and_bits(x, y, 4, 4, 5, 3)) << 9;
        p += or_bits(x, y, 4, 7, 5, 6) << 11;
        p += or_bits(x, y, 2, 7, 3, 6) << 9;
        p += or_bits(x, y, 0, 7, 1, 6) << 8;
        p += (or_bits(x, y, 2, 4, 3, 3) + or_bits(x, y, 2, 5, 3, 4)) << 7;
        p += (or_bits(x, y, 4, 2, 5, 1) + or_bits(x, y, 4, 3, 5, 2)) << 7;
        p += or_bits(x, y, 4, 1, 5, 0) << 5;
        p += xor_bits(x, y, 4, 6, 5, 5) << 10;
        p += xor_bits(x, y, 4, 5, 5, 4) << 9;
        p += (xor_bits(x, y, 2, 6, 3, 5) + xor_bits(x, y, 4, 4, 5, 3)) << 8;
        p += (xor_bits(x, y, 0, 4, 1, 3) + xor_bits(x, y, 2, 2, 3, 1)) << 4;
        p += xor_bits(x, y, 0, 2, 1, 1) << 3;
        return product_t'(p);
    endfunction

    function automatic acc_t window_sum(bias_t b);
        acc_t s;
        s = acc_t'(b);
        for (int t = 0; t < `LENET_TAPS; t++) begin
            s = s + acc_t'(approx_mul(px_buf[t], w_model[t]));
        end
        return s;
    endfunction

    function automatic pixel_t quantize(acc_t s);
        acc_t q;
        q = s >> `LENET_OUT_SHIFT;
        return (q > 255) ? pixel_t'(255) : pixel_t'(q);
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic pix_check(string name, pixel_t got, pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic sum_check(string name, acc_t got, acc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic flag_check(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic load_weights();
        for (int t = 0; t < `LENET_TAPS; t++) begin
            w_we   = 1'b1;
            w_addr = tap_t'(t);
            w_data = w_model[t];
            step_clock();
        end
        w_we = 1'b0;
    endtask

    task automatic random_weights();
        for (int t = 0; t < `LENET_TAPS; t++) begin
            w_model[t] = weight_t'(random_bits(8));
        end
    endtask

    task automatic fill_pixels(int width);
        for (int t = 0; t < `LENET_TAPS; t++) begin
            px_buf[t] = pixel_t'(random_bits(width));
        end
    endtask

    task automatic send_window(bias_t b, int gap_max, bit stray_start);
        result_t r;
        int      gap;
        start = 1'b1;
        bias  = ~b;  // The bias only counts on the first beat.
        step_clock();
        start = 1'b0;
        flag_check("busy", busy, 1'b1);
        for (int t = 0; t < `LENET_TAPS; t++) begin
            gap = (gap_max == 0) ? 0 : int'(random_bits(2)) % (gap_max + 1);
            repeat (gap) step_clock();
            pix_valid = 1'b1;
            pix       = px_buf[t];
            bias      = (t == 0) ? b : ~b;
            start     = stray_start && (t == `LENET_TAPS / 2);  // Must be ignored.
            if (t == `LENET_TAPS - 1) begin
                r.sum = window_sum(b);
                r.pix = quantize(r.sum);
                r.due = cyc + 3;
                exp_q.push_back(r);
            end
            step_clock();
            pix_valid = 1'b0;
            start     = 1'b0;
        end
        flag_check("busy", busy, 1'b0);
    endtask

    // Outputs hold for a whole cycle, so the falling edge sees them settled.
    always @(negedge clk) begin
        result_t e;
        if (!rst && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("out_valid went high with no window outstanding");
            end else begin
                e = exp_q.pop_front();
                if (cyc != e.due) begin
                    abort_run($sformatf("out_valid at cycle %0d, expected at cycle %0d",
                                        cyc, e.due));
                end else begin
                    pix_check("out_pix", out_pix, e.pix);
                    sum_check("out_sum", out_sum, e.sum);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run($sformatf("watchdog expired after %0d ns", TIMEOUT_NS));
    end

    initial begin
        int sel;
        lfsr_state = 16'd61;
        cyc        = 0;
        rst        = 1'b1;
        w_we       = 1'b0;
        w_addr     = '0;
        w_data     = '0;
        start      = 1'b0;
        pix_valid  = 1'b0;
        pix        = '0;
        bias       = '0;
        for (int t = 0; t < `LENET_TAPS; t++) begin
            w_model[t] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        flag_check("busy", busy, 1'b0);
        flag_check("out_valid", out_valid, 1'b0);

        fill_pixels(8);
        send_window(bias_t'(random_bits(16)), 0, 1'b0);  // Weights still zero from reset.

        repeat (6) begin
            for (int t = 0; t < `LENET_TAPS; t++) begin
                w_model[t] = '0;
            end
            sel = int'(random_bits(5)) % `LENET_TAPS;
            w_model[sel] = weight_t'(random_bits(8));
            load_weights();
            fill_pixels(8);
            send_window(bias_t'(random_bits(16)), 0, 1'b0);
        end

        // Narrow pixels keep some sums under the saturation point.
        repeat (8) begin
            random_weights();
            load_weights();
            fill_pixels(3 + int'(random_bits(3)) % 6);
            send_window(bias_t'(random_bits(16)), 0, 1'b0);
        end

        repeat (6) begin
            random_weights();
            load_weights();
            fill_pixels(3 + int'(random_bits(3)) % 6);
            send_window(bias_t'(random_bits(16)), MAX_GAP, 1'b0);
        end

        // Each start goes out in the cycle that busy falls.
        random_weights();
        load_weights();
        repeat (5) begin
            fill_pixels(3 + int'(random_bits(3)) % 6);
            send_window(bias_t'(random_bits(16)), 1, 1'b0);
        end

        repeat (2) begin
            random_weights();
            load_weights();
            fill_pixels(4);
            send_window(bias_t'(random_bits(16)), 0, 1'b1);
        end

        for (int i = 0; i < 8 && exp_q.size() != 0; i++) begin
            step_clock();
        end
        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("results were still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* common/lenet_config.svh */
`ifndef LENET_CONFIG_SVH
`define LENET_CONFIG_SVH

// One weight per position of the 5x5 kernel.
`define LENET_TAPS 25

// 25 products of at most 16 bits plus a 16-bit bias need 21 bits.
`define LENET_ACC_W 21

// Right shift that maps the window sum onto the 8-bit activation range.
`define LENET_OUT_SHIFT 8

`endif

/* common/lenet_pkg.sv */
`default_nettype none

`include "lenet_config.svh"

package lenet_pkg;

    typedef logic [7:0]  pixel_t;
    typedef logic [7:0]  weight_t;
    typedef logic [15:0] product_t;
    typedef logic [15:0] bias_t;
    typedef logic [4:0]  tap_t;

    typedef logic [`LENET_ACC_W-1:0] acc_t;

    // One pixel on its way from the control unit into the MAC pipeline.
    typedef struct packed {
        pixel_t pix;
        bias_t  bias;  // Only meaningful on the first beat.
        logic   first;
        logic   last;
        logic   valid;
    } conv_beat_t;

    typedef enum logic {
        IDLE,
        RUN
    } ctrl_state_t;

endpackage

`default_nettype wire

/* conv/conv_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lenet_config.svh"

module conv_ctrl import lenet_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       pix_valid,
    input  pixel_t     pix,
    input  bias_t      bias,
    output logic       busy,
    output tap_t       tap,
    output conv_beat_t beat
);

    ctrl_state_t state;
    logic        last_tap;
    logic        take;

    assign last_tap = (tap == tap_t'(`LENET_TAPS - 1));
    assign take     = (state == RUN) && pix_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            tap   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                    end
                    tap <= '0;
                end
                RUN: begin
                    if (pix_valid) begin
                        if (last_tap) begin
                            state <= IDLE;  // A new start is welcome next cycle.
                            tap   <= '0;
                        end else begin
                            tap <= tap + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                    tap   <= '0;
                end
            endcase
        end
    end

    assign busy = (state == RUN);

    // The beat leaves in the same cycle as the strobe, so the weight read
    // through tap lines up with it.
    always_comb begin
        beat.pix   = pix;
        beat.bias  = bias;
        beat.first = take && (tap == '0);
        beat.last  = take && last_tap;
        beat.valid = take;
    end

endmodule

`default_nettype wire

/* conv/conv_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_mac import lenet_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  conv_beat_t beat,
    input  weight_t    weight,
    output acc_t       sum,
    output logic       done
);

    product_t prod;
    product_t prod_q;
    bias_t    bias_q;
    logic     valid_q;
    logic     first_q;
    logic     last_q;

    lenet_xwyf_16 mul0 (
        .x (beat.pix),
        .y (weight),
        .z (prod)
    );

    // Stage one.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= beat.valid;
            first_q <= beat.first;
            last_q  <= beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            prod_q <= prod;
            bias_q <= beat.bias;
        end
    end

    // Stage two. The first product of a window restarts the sum from the bias.
    always_ff @(posedge clk) begin
        if (rst) begin
            sum  <= '0;
            done <= 1'b0;
        end else begin
            if (valid_q) begin
                sum <= (first_q ? acc_t'(bias_q) : sum) + acc_t'(prod_q);
            end
            done <= valid_q && last_q;
        end
    end

endmodule

`default_nettype wire

/* conv/conv_weight_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lenet_config.svh"

module conv_weight_mem import lenet_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    we,
    input  tap_t    waddr,
    input  weight_t wdata,
    input  tap_t    raddr,
    output weight_t rdata
);

    weight_t mem [`LENET_TAPS];

    // Reset clears the whole kernel to zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LENET_TAPS; i++) begin
                mem[i] <= '0;
            end
        end else if (we && (waddr < `LENET_TAPS)) begin
            mem[waddr] <= wdata;
        end
    end

    // The tap index only ever counts to 24, but the address is 5 bits wide.
    assign rdata = (raddr < `LENET_TAPS) ? mem[raddr] : '0;

endmodule

`default_nettype wire

/* hw/lenet_conv_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_conv_top import lenet_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    w_we,
    input  tap_t    w_addr,
    input  weight_t w_data,

    input  logic    start,
    input  logic    pix_valid,
    input  pixel_t  pix,
    input  bias_t   bias,

    output logic    busy,
    output logic    out_valid,
    output pixel_t  out_pix,
    output acc_t    out_sum
);

    tap_t       tap;
    weight_t    weight;
    conv_beat_t beat;
    acc_t       sum;
    logic       done;

    conv_weight_mem wmem0 (
        .clk   (clk),
        .rst   (rst),
        .we    (w_we),
        .waddr (w_addr),
        .wdata (w_data),
        .raddr (tap),
        .rdata (weight)
    );

    // Window sequencing and beat tagging.
    conv_ctrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .pix_valid (pix_valid),
        .pix       (pix),
        .bias      (bias),
        .busy      (busy),
        .tap       (tap),
        .beat      (beat)
    );

    conv_mac mac0 (
        .clk    (clk),
        .rst    (rst),
        .beat   (beat),
        .weight (weight),
        .sum    (sum),
        .done   (done)
    );

    out_quant quant0 (
        .clk       (clk),
        .rst       (rst),
        .sum       (sum),
        .done      (done),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_sum   (out_sum)
    );

endmodule

`default_nettype wire

/* hw/lenet_xwyf_16.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_xwyf_16 import lenet_pkg::*; (
    input  pixel_t   x,
    input  weight_t  y,
    output product_t z
);

    weight_t    pp [8];
    logic [12:0] row_a;
    logic [12:0] row_b;
    logic [12:0] row_c;
    logic [12:0] row_d;
    logic [13:0] row_g;
    logic [14:0] row_h;

    // Row i is the weight gated by pixel bit i.
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // The low rows are never summed exactly. Pairs of partial-product bits that
    // share a column are folded into single XOR, OR or AND terms instead.
    assign row_a = {
        pp[5][7],
        pp[4][6] & pp[5][5],
        pp[3][7],
        pp[2][6] & pp[3][5],
        pp[0][7] | pp[1][6],
        pp[2][4] | pp[3][3],
        1'b0,
        pp[4][1] | pp[5][0],
        pp[0][4] ^ pp[1][3],
        pp[0][2] ^ pp[1][1],
        3'b000
    };

    assign row_b = {
        1'b0,
        pp[4][7] & pp[5][6],
        pp[4][5] & pp[5][4],
        pp[2][7] | pp[3][6],
        pp[1][7],
        pp[2][5] | pp[3][4],
        2'b00,
        pp[2][2] ^ pp[3][1],
        4'b0000
    };

    assign row_c = {
        1'b0,
        pp[4][7] | pp[5][6],
        pp[4][6] ^ pp[5][5],
        pp[4][4] & pp[5][3],
        pp[2][6] ^ pp[3][5],
        pp[4][2] | pp[5][1],
        7'b0000000
    };

    assign row_d = {
        3'b000,
        pp[4][5] ^ pp[5][4],
        pp[4][4] ^ pp[5][3],
        pp[4][3] | pp[5][2],
        7'b0000000
    };

    // The two top rows are kept exact.
    assign row_g = {pp[6], 6'b000000};
    assign row_h = {pp[7], 7'b0000000};

    assign z = product_t'(row_g) + product_t'(row_h) + product_t'(row_a)
             + product_t'(row_b) + product_t'(row_c) + product_t'(row_d);

endmodule

`default_nettype wire

/* hw/out_quant.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lenet_config.svh"

module out_quant import lenet_pkg::*; #(
    parameter int OUT_SHIFT = `LENET_OUT_SHIFT
) (
    input  logic   clk,
    input  logic   rst,
    input  acc_t   sum,
    input  logic   done,
    output logic   out_valid,
    output pixel_t out_pix,
    output acc_t   out_sum
);

    acc_t   shifted;
    pixel_t sat;

    assign shifted = sum >> OUT_SHIFT;
    // Anything above the low byte clips to full scale.
    assign sat = (|shifted[$bits(acc_t)-1:$bits(pixel_t)]) ? '1 : shifted[$bits(pixel_t)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            out_pix <= sat;
            out_sum <= sum;  // Raw sum kept for checking.
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/lenet_pkg.sv
hw/lenet_xwyf_16.sv
conv/conv_weight_mem.sv
conv/conv_ctrl.sv
conv/conv_mac.sv
hw/out_quant.sv
hw/lenet_conv_top.sv
bench/lenet_conv_sva.sv
bench/lenet_conv_tb.sv
